// ==== bench/tb_cases.svh ====
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// One row per captured snoop, stimulus first, expected values after
typedef struct packed {
    // Drop enable while idle before the trigger
    logic                  rearm;
    logic [31:0]           control;
    logic [ACE_ADDR_W-1:0] addr;
    logic [3:0]            snoop;
    logic [3:0]            acsnoop;
    logic [31:0]           base;
    logic [31:0]           size;
    logic [31:0]           delay;
    logic [31:0]           pattern;
    logic [4:0]            exp_resp;
    logic                  exp_data;
    logic                  exp_fuzz;
    logic                  exp_end;
    // Zero means the cycle is not checked
    int                    reply_cycles;
    int                    min_cr_cycle;
} case_t;

localparam int NUM_CASES = 9;

case_t case_table [NUM_CASES] = '{
    // Address window miss, dummy reply
    '{1'b0, 32'h0002_9643, 44'h000_0000_9000, 4'h0, 4'h0, 32'h0000_1000, 32'h0000_1000,
      32'd0, 32'h1111_0000, 5'h00, 1'b0, 1'b0, 1'b0, 4, 0},
    // Opcode hit, PDT line substitution
    '{1'b0, 32'h0010_6AA3, 44'h123_4567_89A0, 4'h7, 4'h7, 32'h0000_0000, 32'h0000_0000,
      32'd0, 32'hC0DE_0100, 5'h15, 1'b1, 1'b0, 1'b1, 0, 0},
    // OSH after rearm fires
    '{1'b1, 32'h0001_1225, 44'h000_0000_2000, 4'h1, 4'h0, 32'h0000_0000, 32'h0000_0000,
      32'd0, 32'h0000_0000, 5'h09, 1'b0, 1'b0, 1'b1, 0, 0},
    // Second OSH snoop falls to dummy
    '{1'b0, 32'h0001_1225, 44'h000_0000_2040, 4'h1, 4'h0, 32'h0000_0000, 32'h0000_0000,
      32'd0, 32'h0000_0000, 5'h00, 1'b0, 1'b0, 1'b1, 5, 0},
    // Enable toggled, OSH fires again
    '{1'b1, 32'h0001_1225, 44'h000_0000_2080, 4'h1, 4'h0, 32'h0000_0000, 32'h0000_0000,
      32'd0, 32'h0000_0000, 5'h09, 1'b0, 1'b0, 1'b1, 0, 0},
    // CON, delayed crvalid
    '{1'b1, 32'h0002_3845, 44'h000_0000_3000, 4'h2, 4'h0, 32'h0000_0000, 32'h0000_0000,
      32'd2, 32'h0000_0000, 5'h1C, 1'b0, 1'b0, 1'b0, 0, 8},
    // CON, fuzzing strobes
    '{1'b0, 32'h0002_0643, 44'h000_0000_3100, 4'h3, 4'h0, 32'h0000_0000, 32'h0000_0000,
      32'd0, 32'h0000_0000, 5'h03, 1'b0, 1'b1, 1'b0, 0, 0},
    // Both filters hit, PDT
    '{1'b0, 32'h0010_FEA5, 44'hA00_0000_1800, 4'hB, 4'hB, 32'h0000_1000, 32'h0000_1000,
      32'd0, 32'h5A5A_0200, 5'h1F, 1'b1, 1'b0, 1'b1, 0, 0},
    // ADL code is gone, dummy reply
    '{1'b0, 32'h0000_0E63, 44'h000_0000_4000, 4'h4, 4'h0, 32'h0000_0000, 32'h0000_0000,
      32'd0, 32'h0000_0000, 5'h00, 1'b0, 1'b0, 1'b1, 5, 0}
};

`endif

// ==== bench/tb_passive_devil.sv ====
module tb_passive_devil
    import devil_pkg::*;
();

    localparam int LINE_W        = 4 * ACE_DATA_W;
    localparam int BEATS         = 4;
    localparam int REPLY_TIMEOUT = 200;

    logic              ace_aclk;
    logic              ace_aresetn;
    logic              i_trigger;
    snoop_snapshot_t   i_snapshot;
    logic [31:0]       i_control_reg;
    logic [31:0]       i_delay_reg;
    logic [31:0]       i_acsnoop_reg;
    logic [31:0]       i_base_addr_reg;
    logic [31:0]       i_addr_size_reg;
    logic [LINE_W-1:0] i_cache_line;
    logic              i_crready;
    logic              i_cdready;
    cr_out_t           o_cr;
    cd_out_t           o_cd;
    logic              o_reply;
    logic              o_end;
    logic              o_busy;

    int    errors;
    int    case_errors;
    int    cases_run;
    int    cases_passed;
    logic  timed_out;
    string phase;

    `include "tb_cases.svh"

    passive_devil uut (
        .ace_aclk        (ace_aclk),
        .ace_aresetn     (ace_aresetn),
        .i_trigger       (i_trigger),
        .i_snapshot      (i_snapshot),
        .i_control_reg   (i_control_reg),
        .i_delay_reg     (i_delay_reg),
        .i_acsnoop_reg   (i_acsnoop_reg),
        .i_base_addr_reg (i_base_addr_reg),
        .i_addr_size_reg (i_addr_size_reg),
        .i_cache_line    (i_cache_line),
        .i_crready       (i_crready),
        .i_cdready       (i_cdready),
        .o_cr            (o_cr),
        .o_cd            (o_cd),
        .o_reply         (o_reply),
        .o_end           (o_end),
        .o_busy          (o_busy)
    );

    always #2 ace_aclk = ~ace_aclk;

    // Every 32-bit word of the line carries its own index
    function automatic logic [LINE_W-1:0] make_line(input logic [31:0] pattern);
        logic [LINE_W-1:0] fill;
        int                w;
        fill = '0;
        for (w = 0; w < LINE_W / 32; w++)
            fill[w*32 +: 32] = pattern ^ (32'(w) * 32'h0101_0101);
        return fill;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("ERR %s %s: got %0h expected %0h", phase, name, got, exp);
        errors++;
        case_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s", phase, what);
        errors++;
        case_errors++;
    endtask

    task automatic finish_test();
        cases_run++;
        if (case_errors == 0)
        begin
            cases_passed++;
            $display("%s: ok", phase);
        end
        else
            $display("%s: %0d error(s)", phase, case_errors);
    endtask

    // ------------------------------------------------------------------------
    // One snoop from trigger to o_reply
    // ------------------------------------------------------------------------
    task automatic run_case(input int idx);
        case_t                 tc;
        logic [LINE_W-1:0]     line;
        logic [ACE_DATA_W-1:0] hold_data;
        logic                  hold_pending;
        int                    cyc;
        int                    cr_first;
        int                    cdv_first;
        int                    cdl_first;
        int                    reply_cyc;
        int                    beats;

        tc           = case_table[idx];
        line         = make_line(tc.pattern);
        phase        = $sformatf("case %0d", idx);
        case_errors  = 0;
        cr_first     = -1;
        cdv_first    = -1;
        cdl_first    = -1;
        reply_cyc    = -1;
        beats        = 0;
        hold_pending = 1'b0;
        hold_data    = '0;

        // Enable low for a while in idle clears o_end
        if (tc.rearm)
        begin
            i_control_reg = tc.control & ~32'h1;
            repeat (2) @(posedge ace_aclk);
            #1;
            if (o_end !== 1'b0)
                report_mismatch("o_end after rearm", 128'(o_end), 128'(0));
        end

        i_control_reg   = tc.control;
        i_delay_reg     = tc.delay;
        i_acsnoop_reg   = {28'd0, tc.acsnoop};
        i_base_addr_reg = tc.base;
        i_addr_size_reg = tc.size;
        i_cache_line    = line;
        i_snapshot      = '{addr: tc.addr, snoop: tc.snoop};
        i_trigger       = 1'b1;

        cyc = 0;
        while (reply_cyc < 0 && cyc < REPLY_TIMEOUT)
        begin
            @(negedge ace_aclk);
            if (o_cr.valid && cr_first < 0)
            begin
                cr_first = cyc;
                if (o_cr.resp !== tc.exp_resp)
                    report_mismatch("o_cr.resp", 128'(o_cr.resp), 128'(tc.exp_resp));
            end
            if (o_cd.valid && cdv_first < 0)
                cdv_first = cyc;
            if (o_cd.last && cdl_first < 0)
                cdl_first = cyc;
            if (hold_pending && o_cd.data !== hold_data)
                report_mismatch("o_cd.data during stall", o_cd.data, hold_data);
            hold_pending = o_cd.valid && !i_cdready;
            hold_data    = o_cd.data;
            if (tc.exp_data && o_cd.valid && i_cdready)
            begin
                if (beats < BEATS)
                begin
                    if (o_cd.data !== line[beats*ACE_DATA_W +: ACE_DATA_W])
                        report_mismatch("o_cd.data", o_cd.data,
                                        line[beats*ACE_DATA_W +: ACE_DATA_W]);
                    if (o_cd.last !== (beats == BEATS - 1))
                        report_mismatch("o_cd.last", 128'(o_cd.last),
                                        128'(beats == BEATS - 1));
                end
                beats++;
            end
            // The FSM leaves IDLE on the edge after the trigger
            if (cyc > 0 && !o_reply && o_busy !== 1'b1)
                report_mismatch("o_busy", 128'(o_busy), 128'(1));
            if (o_reply)
                reply_cyc = cyc;
            @(posedge ace_aclk);
            #1;
            i_trigger = 1'b0;
            i_cdready = ($urandom() % 32'd4) != 32'd0;
            cyc++;
        end

        if (reply_cyc < 0)
        begin
            report_problem("timed out waiting for o_reply");
            timed_out = 1'b1;
        end
        else
        begin
            if (cr_first < 0)
                report_problem("crvalid never rose");
            if (tc.reply_cycles != 0 && reply_cyc != tc.reply_cycles)
                report_mismatch("o_reply cycle", 128'(reply_cyc), 128'(tc.reply_cycles));
            if (cr_first >= 0 && cr_first < tc.min_cr_cycle)
                report_problem($sformatf("crvalid rose at cycle %0d, before cycle %0d",
                                         cr_first, tc.min_cr_cycle));
            if (tc.exp_data)
            begin
                if (beats != BEATS)
                    report_mismatch("CD beat count", 128'(beats), 128'(BEATS));
                if (cdv_first <= cr_first)
                    report_problem("cdvalid rose before crvalid");
            end
            else if (tc.exp_fuzz)
            begin
                if (cdv_first != cr_first || cdl_first != cr_first)
                    report_problem("crvalid, cdvalid and cdlast did not rise together");
            end
            else if (cdv_first >= 0)
                report_problem("cdvalid rose on a reply without data");
            if (o_end !== tc.exp_end)
                report_mismatch("o_end", 128'(o_end), 128'(tc.exp_end));
            if (o_busy !== 1'b0)
                report_mismatch("o_busy", 128'(o_busy), 128'(0));
        end
        finish_test();
    endtask

    initial
    begin
        int idx;

        void'($urandom(32'haac4));
        ace_aclk        = 1'b0;
        ace_aresetn     = 1'b0;
        i_trigger       = 1'b0;
        i_snapshot      = '0;
        i_control_reg   = '0;
        i_delay_reg     = '0;
        i_acsnoop_reg   = '0;
        i_base_addr_reg = '0;
        i_addr_size_reg = '0;
        i_cache_line    = '0;
        i_crready       = 1'b1;
        i_cdready       = 1'b1;
        errors          = 0;
        case_errors     = 0;
        cases_run       = 0;
        cases_passed    = 0;
        timed_out       = 1'b0;

        repeat (3) @(posedge ace_aclk);
        #1;
        ace_aresetn = 1'b1;

        // Status right after reset
        phase = "reset";
        if (o_cr.valid !== 1'b0)
            report_mismatch("o_cr.valid", 128'(o_cr.valid), 128'(0));
        if (o_cd.valid !== 1'b0)
            report_mismatch("o_cd.valid", 128'(o_cd.valid), 128'(0));
        if (o_cd.last !== 1'b0)
            report_mismatch("o_cd.last", 128'(o_cd.last), 128'(0));
        if (o_reply !== 1'b0)
            report_mismatch("o_reply", 128'(o_reply), 128'(0));
        if (o_end !== 1'b0)
            report_mismatch("o_end", 128'(o_end), 128'(0));
        if (o_busy !== 1'b0)
            report_mismatch("o_busy", 128'(o_busy), 128'(0));
        finish_test();

        for (idx = 0; idx < NUM_CASES && !timed_out; idx++)
            run_case(idx);

        $display("tests: %0d run, %0d ok, %0d with errors",
                 cases_run, cases_passed, cases_run - cases_passed);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+bench
source/devil_pkg.sv
source/snoop_filter.sv
source/reply_delay_timer.sv
source/snoop_data_burst.sv
source/passive_devil_fsm.sv
source/passive_devil.sv
bench/tb_passive_devil.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the passive_devil testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f filelist.f \
    --top-module tb_passive_devil \
    -o sim_passive_devil

./obj_dir/sim_passive_devil | tee sim.log

if grep -qx "test passed" sim.log
then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== source/devil_pkg.sv ====
package devil_pkg;

    // ------------------------------------------------------------------------
    // Channel widths
    // ------------------------------------------------------------------------
    localparam int ACE_ADDR_W    = 44;
    localparam int ACE_DATA_W    = 128;
    // Only the low part of the snoop address is windowed
    localparam int FILTER_ADDR_W = 32;

    // Manipulation function codes
    typedef enum logic [3:0] {
        FUNC_OSH = 4'd1,
        FUNC_CON = 4'd2,
        FUNC_ADL = 4'd3,
        FUNC_ADT = 4'd4,
        FUNC_PDT = 4'd5
    } func_e;

    // Reply timing, unknown codes act as fuzzing
    typedef enum logic [3:0] {
        TEST_FUZZING       = 4'd1,
        TEST_DELAY_CRVALID = 4'd2
    } test_e;

    typedef enum logic [3:0] {
        IDLE,
        FILTER,
        FUNCTION,
        ONE_SHOT_WAIT,
        CONT_WAIT,
        RESPONSE,
        DELAY,
        REPLY,
        REPLY_DATA,
        DUMMY_REPLY,
        END_OP,
        END_REPLY
    } devil_state_e;

    // ------------------------------------------------------------------------
    // Control register layout, MSB first
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [10:0] rsvd_hi;
        logic        pdt_en;
        // Former active-half enables
        logic [1:0]  rsvd_mid;
        logic        con_en;
        logic        osh_en;
        logic        addr_filter_en;
        logic        ac_filter_en;
        logic [4:0]  crresp;
        func_e       func;
        test_e       test_mode;
        logic        enable;
    } ctrl_t;

    // Snoop request as captured on the AC channel
    typedef struct packed {
        logic [ACE_ADDR_W-1:0] addr;
        logic [3:0]            snoop;
    } snoop_snapshot_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] resp;
    } cr_out_t;

    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [ACE_DATA_W-1:0] data;
    } cd_out_t;

endpackage

// ==== source/passive_devil.sv ====
module passive_devil
    import devil_pkg::*;
#(
    parameter int ACE_ADDR_W        = devil_pkg::ACE_ADDR_W,
    parameter int ACE_DATA_W        = devil_pkg::ACE_DATA_W,
    parameter int BEATS_PER_LINE    = 4,
    parameter int DELAY_UNIT_CYCLES = 4
) (
    input  logic                                 ace_aclk,
    input  logic                                 ace_aresetn,
    input  logic                                 i_trigger,
    input  snoop_snapshot_t                      i_snapshot,
    input  logic [31:0]                          i_control_reg,
    input  logic [31:0]                          i_delay_reg,
    input  logic [31:0]                          i_acsnoop_reg,
    input  logic [31:0]                          i_base_addr_reg,
    input  logic [31:0]                          i_addr_size_reg,
    input  logic [BEATS_PER_LINE*ACE_DATA_W-1:0] i_cache_line,
    input  logic                                 i_crready,
    input  logic                                 i_cdready,
    output cr_out_t                              o_cr,
    output cd_out_t                              o_cd,
    output logic                                 o_reply,
    output logic                                 o_end,
    output logic                                 o_busy
);

    ctrl_t      ctrl;
    cd_out_t    burst_cd;
    logic [1:0] force_cd;
    logic       match;
    logic       delay_start;
    logic       delay_done;
    logic       burst_start;
    logic       burst_done;

    // Channel structs are sized by the package widths
    if (ACE_ADDR_W != $bits(i_snapshot.addr) || ACE_DATA_W != $bits(o_cd.data))
    begin : g_width_check
        $error("passive_devil: width parameters differ from the channel structs");
    end

    assign ctrl = ctrl_t'(i_control_reg);

    snoop_filter u_filter (
        .i_snapshot       (i_snapshot),
        .i_acsnoop_ref    (i_acsnoop_reg[3:0]),
        .i_base_addr      (i_base_addr_reg[FILTER_ADDR_W-1:0]),
        .i_addr_size      (i_addr_size_reg[FILTER_ADDR_W-1:0]),
        .i_ac_filter_en   (ctrl.ac_filter_en),
        .i_addr_filter_en (ctrl.addr_filter_en),
        .o_match          (match)
    );

    reply_delay_timer #(
        .DELAY_UNIT_CYCLES (DELAY_UNIT_CYCLES)
    ) u_timer (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_start     (delay_start),
        .i_delay_sel (i_delay_reg),
        .o_done      (delay_done)
    );

    snoop_data_burst #(
        .BEATS_PER_LINE (BEATS_PER_LINE),
        .ACE_DATA_W     (ACE_DATA_W)
    ) u_burst (
        .ace_aclk     (ace_aclk),
        .ace_aresetn  (ace_aresetn),
        .i_start      (burst_start),
        .i_cache_line (i_cache_line),
        .i_cdready    (i_cdready),
        .o_cd         (burst_cd),
        .o_done       (burst_done)
    );

    passive_devil_fsm u_fsm (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_trigger     (i_trigger),
        .i_ctrl        (ctrl),
        .i_match       (match),
        .i_crready     (i_crready),
        .i_delay_done  (delay_done),
        .i_burst_done  (burst_done),
        .o_cr          (o_cr),
        .o_delay_start (delay_start),
        .o_burst_start (burst_start),
        .o_force_cd    (force_cd),
        .o_reply       (o_reply),
        .o_end         (o_end),
        .o_busy        (o_busy)
    );

    // Fuzzing strobes overlay the burst, data is zero outside a burst
    always_comb
    begin
        o_cd.valid = burst_cd.valid | force_cd[1];
        o_cd.last  = burst_cd.last | force_cd[0];
        o_cd.data  = burst_cd.valid ? burst_cd.data : '0;
    end

endmodule

// ==== source/passive_devil_fsm.sv ====
module passive_devil_fsm
    import devil_pkg::*;
(
    input  logic       ace_aclk,
    input  logic       ace_aresetn,
    input  logic       i_trigger,
    input  ctrl_t      i_ctrl,
    input  logic       i_match,
    input  logic       i_crready,
    input  logic       i_delay_done,
    input  logic       i_burst_done,
    output cr_out_t    o_cr,
    output logic       o_delay_start,
    output logic       o_burst_start,
    // Bit 1 forces cdvalid, bit 0 forces cdlast
    output logic [1:0] o_force_cd,
    output logic       o_reply,
    output logic       o_end,
    output logic       o_busy
);

    devil_state_e state;
    devil_state_e ret_state;
    logic         burst_on;
    logic         delay_mode;

    assign delay_mode    = (i_ctrl.test_mode == TEST_DELAY_CRVALID);
    assign o_delay_start = (state == RESPONSE) && delay_mode;
    // Data burst follows once crvalid is up
    assign o_burst_start = (state == REPLY_DATA) && !burst_on;
    assign o_busy        = (state != IDLE);

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state      <= IDLE;
            ret_state  <= END_REPLY;
            burst_on   <= 1'b0;
            o_cr       <= '0;
            o_force_cd <= '0;
            o_reply    <= 1'b0;
            o_end      <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    o_reply <= 1'b0;
                    if (i_trigger)
                        state <= FILTER;
                    // Dropping enable rearms the one-shot
                    if (o_end && !i_ctrl.enable)
                        o_end <= 1'b0;
                end
                FILTER:
                    state <= i_match ? FUNCTION : DUMMY_REPLY;
                FUNCTION:
                begin
                    case (i_ctrl.func)
                        FUNC_OSH:
                            state <= (i_ctrl.osh_en && !o_end) ? ONE_SHOT_WAIT : DUMMY_REPLY;
                        FUNC_CON:
                            state <= i_ctrl.con_en ? CONT_WAIT : DUMMY_REPLY;
                        FUNC_PDT:
                            state <= i_ctrl.pdt_en ? REPLY : DUMMY_REPLY;
                        default:
                            state <= DUMMY_REPLY;
                    endcase
                end
                ONE_SHOT_WAIT:
                begin
                    if (i_crready)
                    begin
                        ret_state <= END_OP;
                        state     <= RESPONSE;
                    end
                end
                CONT_WAIT:
                begin
                    if (i_crready)
                    begin
                        ret_state <= END_REPLY;
                        state     <= RESPONSE;
                    end
                end
                RESPONSE:
                begin
                    o_cr.resp <= i_ctrl.crresp;
                    if (delay_mode)
                    begin
                        // Zero delay completes right away
                        if (i_delay_done)
                        begin
                            o_cr.valid <= 1'b1;
                            state      <= ret_state;
                        end
                        else
                            state <= DELAY;
                    end
                    else
                    begin
                        o_cr.valid <= 1'b1;
                        o_force_cd <= 2'b11;
                        state      <= ret_state;
                    end
                end
                DELAY:
                begin
                    if (i_delay_done)
                    begin
                        o_cr.valid <= 1'b1;
                        state      <= ret_state;
                    end
                end
                REPLY:
                begin
                    if (i_crready)
                    begin
                        o_cr  <= '{valid: 1'b1, resp: i_ctrl.crresp};
                        state <= REPLY_DATA;
                    end
                end
                REPLY_DATA:
                begin
                    burst_on <= 1'b1;
                    if (i_burst_done)
                        state <= END_OP;
                end
                DUMMY_REPLY:
                begin
                    if (i_crready)
                    begin
                        o_cr  <= '{valid: 1'b1, resp: 5'd0};
                        state <= END_REPLY;
                    end
                end
                END_OP, END_REPLY:
                begin
                    o_cr       <= '0;
                    o_force_cd <= '0;
                    burst_on   <= 1'b0;
                    o_reply    <= 1'b1;
                    if (state == END_OP)
                        o_end <= 1'b1;
                    state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    a_legal_state: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        state inside {IDLE, FILTER, FUNCTION, ONE_SHOT_WAIT, CONT_WAIT, RESPONSE,
                      DELAY, REPLY, REPLY_DATA, DUMMY_REPLY, END_OP, END_REPLY});

endmodule

// ==== source/reply_delay_timer.sv ====
module reply_delay_timer #(
    parameter int DELAY_UNIT_CYCLES = 4
) (
    input  logic        ace_aclk,
    input  logic        ace_aresetn,
    input  logic        i_start,
    input  logic [31:0] i_delay_sel,
    output logic        o_done
);

    logic        counting;
    logic        no_delay;
    logic [31:0] count;
    logic [31:0] target;

    assign no_delay = (i_delay_sel == 32'd0);

    // Zero delay answers in the start cycle itself
    assign o_done = (i_start && no_delay) || (counting && (count == target));

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
            counting <= 1'b0;
        else if (i_start && !no_delay)
            counting <= 1'b1;
        else if (o_done)
            counting <= 1'b0;
    end

    // Exponential steps, unit << (sel - 1)
    always_ff @(posedge ace_aclk)
    begin
        if (i_start)
        begin
            count  <= '0;
            target <= 32'(DELAY_UNIT_CYCLES) << (i_delay_sel - 32'd1);
        end
        else if (counting)
            count <= count + 32'd1;
    end

    a_no_restart: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        counting |-> !i_start);

endmodule

// ==== source/snoop_data_burst.sv ====
module snoop_data_burst
    import devil_pkg::*;
#(
    parameter int BEATS_PER_LINE = 4,
    parameter int ACE_DATA_W     = devil_pkg::ACE_DATA_W
) (
    input  logic                                 ace_aclk,
    input  logic                                 ace_aresetn,
    input  logic                                 i_start,
    input  logic [BEATS_PER_LINE*ACE_DATA_W-1:0] i_cache_line,
    input  logic                                 i_cdready,
    output cd_out_t                              o_cd,
    output logic                                 o_done
);

    localparam int BEAT_W = (BEATS_PER_LINE > 1) ? $clog2(BEATS_PER_LINE) : 1;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BEATS_PER_LINE - 1);

    logic                  beat_valid;
    logic                  beat_last;
    logic                  accept;
    logic [BEAT_W-1:0]     beat;
    logic [BEAT_W-1:0]     next_beat;
    logic [ACE_DATA_W-1:0] beat_data;

    assign accept    = beat_valid && i_cdready;
    assign next_beat = i_start ? '0 : beat + BEAT_W'(1);

    // Completion of the final beat
    assign o_done = accept && beat_last;

    // ------------------------------------------------------------------------
    // Beat sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
            beat       <= '0;
        end
        else if (i_start)
        begin
            beat_valid <= 1'b1;
            beat_last  <= (LAST_BEAT == '0);
            beat       <= '0;
        end
        else if (accept)
        begin
            if (beat_last)
            begin
                beat_valid <= 1'b0;
                beat_last  <= 1'b0;
            end
            else
            begin
                beat      <= next_beat;
                beat_last <= (next_beat == LAST_BEAT);
            end
        end
    end

    // Slice only moves on an accepted beat
    always_ff @(posedge ace_aclk)
    begin
        if (i_start || (accept && !beat_last))
            beat_data <= i_cache_line[next_beat*ACE_DATA_W +: ACE_DATA_W];
    end

    assign o_cd = '{valid: beat_valid, last: beat_last, data: beat_data};

    a_last_has_valid: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_cd.last |-> o_cd.valid);

    a_data_hold: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (o_cd.valid && !i_cdready) |=> ($stable(o_cd.data) && $stable(o_cd.last)));

endmodule

// ==== source/snoop_filter.sv ====
module snoop_filter
    import devil_pkg::*;
(
    input  snoop_snapshot_t          i_snapshot,
    input  logic [3:0]               i_acsnoop_ref,
    input  logic [FILTER_ADDR_W-1:0] i_base_addr,
    input  logic [FILTER_ADDR_W-1:0] i_addr_size,
    input  logic                     i_ac_filter_en,
    input  logic                     i_addr_filter_en,
    output logic                     o_match
);

    logic [FILTER_ADDR_W-1:0] addr_low;
    logic [FILTER_ADDR_W:0]   window_end;
    logic                     opcode_hit;
    logic                     window_hit;

    assign addr_low = i_snapshot.addr[FILTER_ADDR_W-1:0];

    // One extra bit so a window touching the top of the range does not wrap
    assign window_end = {1'b0, i_base_addr} + {1'b0, i_addr_size};

    assign opcode_hit = (i_snapshot.snoop == i_acsnoop_ref);
    assign window_hit = (addr_low >= i_base_addr) && ({1'b0, addr_low} < window_end);

    // A disabled check passes everything
    assign o_match = (opcode_hit || !i_ac_filter_en) && (window_hit || !i_addr_filter_en);

endmodule
